/* hdl/clock_defs.svh */
// Clock constants for the divider ratios, unit limits, widths and segment patterns
`ifndef CLOCK_DEFS_SVH
`define CLOCK_DEFS_SVH

// ----------------------------------------------------------------------
// Divider ratios in clk cycles
// ----------------------------------------------------------------------
`define TICK_DIV      50000000
`define SCAN_DIV      5000
`define DEBOUNCE_DIV  500000

// Top value of each time unit
`define SEC_MAX       59
`define MIN_MAX       59
`define HOU_MAX       23

`define UNIT_W        6
`define DIGITS        6
`define SEG_W         7

// ----------------------------------------------------------------------
// Segment patterns, segment a in the MSB down to segment g in the LSB
// ----------------------------------------------------------------------
`define SEG_0         7'b111_1110
`define SEG_1         7'b011_0000
`define SEG_2         7'b110_1101
`define SEG_3         7'b111_1001
`define SEG_4         7'b011_0011
`define SEG_5         7'b101_1011
`define SEG_6         7'b101_1111
`define SEG_7         7'b111_0000
`define SEG_8         7'b111_1111
`define SEG_9         7'b111_0011
`define SEG_BLANK     7'b000_0000

`endif

/* hdl/clock_pkg.sv */
// Shared types of the digital clock for mode, position, time unit, digit and segment
`include "clock_defs.svh"

package clock_pkg;

	// ----------------------------------------------------------------------
	// Control state held by the button front end
	// ----------------------------------------------------------------------

	// Operating mode, stepped by the mode button
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'b00,
		MODE_SETUP = 2'b01,
		MODE_ALARM = 2'b10
	} mode_t;

	// Unit selected for editing
	typedef enum logic [1:0] {
		POS_SEC = 2'b00,
		POS_MIN = 2'b01,
		POS_HOU = 2'b10
	} pos_t;

	// ----------------------------------------------------------------------
	// Datapath values
	// ----------------------------------------------------------------------
	typedef logic [`UNIT_W-1:0] unit_t;

	// One decimal digit, 0 to 9
	typedef logic [3:0] digit_t;

	typedef logic [`SEG_W-1:0] seg_t;

endpackage

/* hdl/button_decode.sv */
// Button front end that debounces the four buttons and holds mode, position and alarm enable
`timescale 1ns/100ps
`include "clock_defs.svh"

module button_decode #(
	parameter int DEBOUNCE_DIV = `DEBOUNCE_DIV
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_btn_mode,
	input  logic             i_btn_pos,
	input  logic             i_btn_inc,
	input  logic             i_btn_alarm,
	output clock_pkg::mode_t o_mode,
	output clock_pkg::pos_t  o_pos,
	output logic             o_alarm_en,
	output logic             o_inc
);
	import clock_pkg::*;

	localparam int CNT_W = (DEBOUNCE_DIV > 1) ? $clog2(DEBOUNCE_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DEBOUNCE_DIV - 1);

	// Bit positions in the button vectors
	localparam int BTN_MODE  = 0;
	localparam int BTN_POS   = 1;
	localparam int BTN_INC   = 2;
	localparam int BTN_ALARM = 3;

	logic [CNT_W-1:0] div_cnt;
	logic             sample_tick;
	logic [3:0]       btn_meta;
	logic [3:0]       btn_sync;
	logic [3:0]       smp_new;
	logic [3:0]       smp_old;
	logic [3:0]       press;

	// ----------------------------------------------------------------------
	// Input synchronizer and sample-tick divider
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			btn_meta <= '0;
			btn_sync <= '0;
		end else begin
			btn_meta <= {i_btn_alarm, i_btn_inc, i_btn_pos, i_btn_mode};
			btn_sync <= btn_meta;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
		end else if (div_cnt == CNT_LAST) begin
			div_cnt <= '0;
		end else begin
			div_cnt <= div_cnt + 1'b1;
		end
	end

	assign sample_tick = (div_cnt == CNT_LAST);

	// Two most recent samples per button
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			smp_new <= '0;
			smp_old <= '0;
		end else if (sample_tick) begin
			smp_new <= btn_sync;
			smp_old <= smp_new;
		end
	end

	// High now and at the last sample, low the sample before
	assign press = {4{sample_tick}} & btn_sync & smp_new & ~smp_old;

	// ----------------------------------------------------------------------
	// Control state
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= MODE_CLOCK;
			o_pos      <= POS_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (press[BTN_MODE]) begin
				case (o_mode)
					MODE_CLOCK: o_mode <= MODE_SETUP;
					MODE_SETUP: o_mode <= MODE_ALARM;
					default:    o_mode <= MODE_CLOCK;
				endcase
			end
			if (press[BTN_POS]) begin
				case (o_pos)
					POS_SEC: o_pos <= POS_MIN;
					POS_MIN: o_pos <= POS_HOU;
					default: o_pos <= POS_SEC;
				endcase
			end
			if (press[BTN_ALARM]) begin
				o_alarm_en <= ~o_alarm_en;
			end
		end
	end

	// Increment is consumed downstream as a single-cycle pulse
	assign o_inc = press[BTN_INC];

endmodule

/* hdl/hms_counter.sv */
// Modulo counter for one time unit with step enable and a wrap flag for the carry chain
`timescale 1ns/100ps
`include "clock_defs.svh"

module hms_counter #(
	parameter int MAX = `SEC_MAX
) (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             i_step,
	output clock_pkg::unit_t o_count,
	output logic             o_wrap
);
	import clock_pkg::*;

	localparam unit_t MAX_V = unit_t'(MAX);

	logic at_max;

	assign at_max = (o_count == MAX_V);

	// ----------------------------------------------------------------------
	// Count register
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_count <= '0;
		end else if (i_step) begin
			if (at_max) begin
				o_count <= '0;
			end else begin
				o_count <= o_count + 1'b1;
			end
		end
	end

	// Same cycle as the step that returns the count to zero
	assign o_wrap = i_step & at_max;

endmodule

/* hdl/time_keeper.sv */
// Time keeper with the second tick, running and alarm counters, display select and alarm latch
`timescale 1ns/100ps
`include "clock_defs.svh"

module time_keeper #(
	parameter int TICK_DIV = `TICK_DIV
) (
	input  logic             clk,
	input  logic             rst_n,
	input  clock_pkg::mode_t i_mode,
	input  clock_pkg::pos_t  i_pos,
	input  logic             i_inc,
	input  logic             i_alarm_en,
	output clock_pkg::unit_t o_sec,
	output clock_pkg::unit_t o_min,
	output clock_pkg::unit_t o_hou,
	output logic             o_alarm
);
	import clock_pkg::*;

	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

	logic [CNT_W-1:0] tick_cnt;
	logic             running;
	logic             sec_tick;
	logic             set_edit;
	logic             alm_edit;

	logic  run_sec_step, run_min_step, run_hou_step;
	logic  alm_sec_step, alm_min_step, alm_hou_step;
	logic  run_sec_wrap, run_min_wrap;
	unit_t run_sec, run_min, run_hou;
	unit_t alm_sec, alm_min, alm_hou;
	logic  time_match;

	// ----------------------------------------------------------------------
	// Second tick, held while the time is being set
	// ----------------------------------------------------------------------
	assign running = (i_mode != MODE_SETUP);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			tick_cnt <= '0;
		end else if (running) begin
			if (tick_cnt == CNT_LAST) begin
				tick_cnt <= '0;
			end else begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	assign sec_tick = running & (tick_cnt == CNT_LAST);

	// ----------------------------------------------------------------------
	// Step selection
	// ----------------------------------------------------------------------
	assign set_edit = (i_mode == MODE_SETUP) & i_inc;
	assign alm_edit = (i_mode == MODE_ALARM) & i_inc;

	// Carries only while running so that edits wrap on their own
	assign run_sec_step = sec_tick | (set_edit & (i_pos == POS_SEC));
	assign run_min_step = (run_sec_wrap & running) | (set_edit & (i_pos == POS_MIN));
	assign run_hou_step = (run_min_wrap & running) | (set_edit & (i_pos == POS_HOU));

	assign alm_sec_step = alm_edit & (i_pos == POS_SEC);
	assign alm_min_step = alm_edit & (i_pos == POS_MIN);
	assign alm_hou_step = alm_edit & (i_pos == POS_HOU);

	// Running time
	hms_counter #(.MAX(`SEC_MAX)) u_run_sec (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_step  (run_sec_step),
		.o_count (run_sec),
		.o_wrap  (run_sec_wrap)
	);

	hms_counter #(.MAX(`MIN_MAX)) u_run_min (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_step  (run_min_step),
		.o_count (run_min),
		.o_wrap  (run_min_wrap)
	);

	hms_counter #(.MAX(`HOU_MAX)) u_run_hou (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_step  (run_hou_step),
		.o_count (run_hou),
		.o_wrap  ()
	);

	// Alarm time
	hms_counter #(.MAX(`SEC_MAX)) u_alm_sec (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_step  (alm_sec_step),
		.o_count (alm_sec),
		.o_wrap  ()
	);

	hms_counter #(.MAX(`MIN_MAX)) u_alm_min (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_step  (alm_min_step),
		.o_count (alm_min),
		.o_wrap  ()
	);

	hms_counter #(.MAX(`HOU_MAX)) u_alm_hou (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_step  (alm_hou_step),
		.o_count (alm_hou),
		.o_wrap  ()
	);

	// ----------------------------------------------------------------------
	// Display select and alarm latch
	// ----------------------------------------------------------------------
	always_comb begin
		if (i_mode == MODE_ALARM) begin
			o_sec = alm_sec;
			o_min = alm_min;
			o_hou = alm_hou;
		end else begin
			o_sec = run_sec;
			o_min = run_min;
			o_hou = run_hou;
		end
	end

	assign time_match = (run_sec == alm_sec) & (run_min == alm_min) & (run_hou == alm_hou);

	// Sets on a match and holds until the alarm is disabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (o_alarm | time_match);
		end
	end

endmodule

/* hdl/display_scan.sv */
// Six-digit display scanner with digit split, segment decode and active-low digit enables
`timescale 1ns/100ps
`include "clock_defs.svh"

module display_scan #(
	parameter int SCAN_DIV = `SCAN_DIV
) (
	input  logic                clk,
	input  logic                rst_n,
	input  clock_pkg::unit_t    i_sec,
	input  clock_pkg::unit_t    i_min,
	input  clock_pkg::unit_t    i_hou,
	output clock_pkg::seg_t     o_seg,
	output logic [`DIGITS-1:0]  o_seg_enb
);
	import clock_pkg::*;

	localparam int CNT_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(SCAN_DIV - 1);
	localparam int IDX_W = $clog2(`DIGITS);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(`DIGITS - 1);
	localparam logic [`DIGITS-1:0] ENB_ONE = {{(`DIGITS-1){1'b0}}, 1'b1};

	logic [CNT_W-1:0] scan_cnt;
	logic [IDX_W-1:0] scan_idx;
	digit_t           digits [`DIGITS];

	// Segment table, anything past 9 is blanked
	function automatic seg_t seg_decode(input digit_t d);
		case (d)
			4'd0:    return `SEG_0;
			4'd1:    return `SEG_1;
			4'd2:    return `SEG_2;
			4'd3:    return `SEG_3;
			4'd4:    return `SEG_4;
			4'd5:    return `SEG_5;
			4'd6:    return `SEG_6;
			4'd7:    return `SEG_7;
			4'd8:    return `SEG_8;
			4'd9:    return `SEG_9;
			default: return `SEG_BLANK;
		endcase
	endfunction

	// ----------------------------------------------------------------------
	// Digit split, ones before tens for each unit
	// ----------------------------------------------------------------------
	always_comb begin
		digits[0] = digit_t'(i_sec % 6'd10);
		digits[1] = digit_t'(i_sec / 6'd10);
		digits[2] = digit_t'(i_min % 6'd10);
		digits[3] = digit_t'(i_min / 6'd10);
		digits[4] = digit_t'(i_hou % 6'd10);
		digits[5] = digit_t'(i_hou / 6'd10);
	end

	// ----------------------------------------------------------------------
	// Scan divider and digit index
	// ----------------------------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			scan_cnt <= '0;
			scan_idx <= '0;
		end else if (scan_cnt == CNT_LAST) begin
			scan_cnt <= '0;
			if (scan_idx == IDX_LAST) begin
				scan_idx <= '0;
			end else begin
				scan_idx <= scan_idx + 1'b1;
			end
		end else begin
			scan_cnt <= scan_cnt + 1'b1;
		end
	end

	// Pattern and enable registered together so they never disagree
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_seg     <= `SEG_0;
			o_seg_enb <= ~ENB_ONE;
		end else begin
			o_seg     <= seg_decode(digits[scan_idx]);
			o_seg_enb <= ~(ENB_ONE << scan_idx);
		end
	end

endmodule

/* hdl/digital_clock.sv */
// Digital clock top level joining the button decode, time keeper and display scan stages
`timescale 1ns/100ps
`include "clock_defs.svh"

module digital_clock #(
	parameter int TICK_DIV     = `TICK_DIV,
	parameter int SCAN_DIV     = `SCAN_DIV,
	parameter int DEBOUNCE_DIV = `DEBOUNCE_DIV
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               i_btn_mode,
	input  logic               i_btn_pos,
	input  logic               i_btn_inc,
	input  logic               i_btn_alarm,
	output clock_pkg::seg_t    o_seg,
	output logic [`DIGITS-1:0] o_seg_enb,
	output logic               o_alarm
);
	import clock_pkg::*;

	mode_t mode;
	pos_t  pos;
	logic  alarm_en;
	logic  inc;
	unit_t disp_sec;
	unit_t disp_min;
	unit_t disp_hou;

	// ----------------------------------------------------------------------
	// Decode, execute and result stages
	// ----------------------------------------------------------------------
	button_decode #(.DEBOUNCE_DIV(DEBOUNCE_DIV)) u_button_decode (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (i_btn_mode),
		.i_btn_pos   (i_btn_pos),
		.i_btn_inc   (i_btn_inc),
		.i_btn_alarm (i_btn_alarm),
		.o_mode      (mode),
		.o_pos       (pos),
		.o_alarm_en  (alarm_en),
		.o_inc       (inc)
	);

	time_keeper #(.TICK_DIV(TICK_DIV)) u_time_keeper (
		.clk        (clk),
		.rst_n      (rst_n),
		.i_mode     (mode),
		.i_pos      (pos),
		.i_inc      (inc),
		.i_alarm_en (alarm_en),
		.o_sec      (disp_sec),
		.o_min      (disp_min),
		.o_hou      (disp_hou),
		.o_alarm    (o_alarm)
	);

	display_scan #(.SCAN_DIV(SCAN_DIV)) u_display_scan (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_sec     (disp_sec),
		.i_min     (disp_min),
		.i_hou     (disp_hou),
		.o_seg     (o_seg),
		.o_seg_enb (o_seg_enb)
	);

endmodule

/* sim/tb_digital_clock.sv */
// Testbench for the digital clock that presses the buttons and checks the scanned display and alarm
`timescale 1ns/100ps
`include "clock_defs.svh"

module tb_digital_clock;

	localparam int TICK_DIV     = 400;
	localparam int SCAN_DIV     = 4;
	localparam int DEBOUNCE_DIV = 2;
	localparam int HALF_PERIOD  = 20;
	localparam int PRESS_HOLD   = 4 * DEBOUNCE_DIV;
	localparam int PRESS_CYC    = 2 * PRESS_HOLD;
	localparam int SCAN_CYC     = `DIGITS * SCAN_DIV;
	localparam int READ_CYC     = 5 * SCAN_CYC;
	localparam int RUN_SECS     = 3;
	localparam int DAY          = 86400;

	localparam int B_MODE  = 0;
	localparam int B_POS   = 1;
	localparam int B_INC   = 2;
	localparam int B_ALARM = 3;
	localparam int U_SEC   = 0;
	localparam int U_MIN   = 1;
	localparam int U_HOU   = 2;

	// Upper bound of each test in clk cycles
	localparam int T1_CYC    = 10 + READ_CYC;
	localparam int T2_CYC    = 180 * PRESS_CYC + 3 * READ_CYC;
	localparam int T3_CYC    = 25 * PRESS_CYC + READ_CYC;
	localparam int T4_CYC    = 150 * PRESS_CYC + 2 * READ_CYC + (RUN_SECS + 1) * TICK_DIV;
	localparam int T5_CYC    = 150 * PRESS_CYC + 4 * READ_CYC + 12 * TICK_DIV;
	localparam int LIMIT_CYC = 2 * (T1_CYC + T2_CYC + T3_CYC + T4_CYC + T5_CYC);

	logic clk;
	logic rst_n;
	logic i_btn_mode;
	logic i_btn_pos;
	logic i_btn_inc;
	logic i_btn_alarm;
	logic [`SEG_W-1:0]  seg;
	logic [`DIGITS-1:0] seg_enb;
	logic alarm;

	// Last pattern seen per digit
	logic [`DIGITS-1:0][`SEG_W-1:0] got;
	// Model times in seconds of the day
	int   run_t;
	int   alm_t;
	int   exp_t;
	logic cmp_req = 1'b0;
	logic cmp_ack = 1'b0;

	digital_clock #(
		.TICK_DIV     (TICK_DIV),
		.SCAN_DIV     (SCAN_DIV),
		.DEBOUNCE_DIV (DEBOUNCE_DIV)
	) DUT (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_btn_mode  (i_btn_mode),
		.i_btn_pos   (i_btn_pos),
		.i_btn_inc   (i_btn_inc),
		.i_btn_alarm (i_btn_alarm),
		.o_seg       (seg),
		.o_seg_enb   (seg_enb),
		.o_alarm     (alarm)
	);

	always #(HALF_PERIOD) clk = ~clk;

	// ----------------------------------------------------------------------
	// Reference model
	// ----------------------------------------------------------------------
	function automatic int unit_of(input int t, input int u);
		case (u)
			U_SEC:   return t % 60;
			U_MIN:   return (t / 60) % 60;
			default: return t / 3600;
		endcase
	endfunction

	// One unit steps on its own with no carry into the next
	function automatic int bump_unit(input int t, input int u, input int n);
		int m;
		int w;
		m = (u == U_HOU) ? 24 : 60;
		w = (u == U_SEC) ? 1 : ((u == U_MIN) ? 60 : 3600);
		return t + (((unit_of(t, u) + n) % m) - unit_of(t, u)) * w;
	endfunction

	function automatic int steps_to(input int t, input int u, input int target);
		int m;
		m = (u == U_HOU) ? 24 : 60;
		return (target - unit_of(t, u) + m) % m;
	endfunction

	// Digit 0 is the seconds ones and digit 5 the hours tens
	function automatic logic [`SEG_W-1:0] ref_seg(input int t, input int idx);
		int v;
		int d;
		v = unit_of(t, idx / 2);
		d = (idx % 2 == 0) ? v % 10 : v / 10;
		case (d)
			0:       return `SEG_0;
			1:       return `SEG_1;
			2:       return `SEG_2;
			3:       return `SEG_3;
			4:       return `SEG_4;
			5:       return `SEG_5;
			6:       return `SEG_6;
			7:       return `SEG_7;
			8:       return `SEG_8;
			9:       return `SEG_9;
			default: return `SEG_BLANK;
		endcase
	endfunction

	function automatic bit scan_matches(input int t);
		bit same;
		same = 1'b1;
		for (int k = 0; k < `DIGITS; k++) begin
			if (got[k] != ref_seg(t, k)) begin
				same = 1'b0;
			end
		end
		return same;
	endfunction

	// ----------------------------------------------------------------------
	// Error reporting
	// ----------------------------------------------------------------------
	task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
		$display("ERROR: %s expected 0x%0h actual 0x%0h", name, exp, act);
		$display("Test failed");
		$fatal(1, "value mismatch");
	endtask

	task automatic fail_check(input string what);
		$display("Check failed: %s", what);
		$display("Test failed");
		$fatal(1, "check failed");
	endtask

	// ----------------------------------------------------------------------
	// Stimulus and display readout
	// ----------------------------------------------------------------------
	task automatic drive_button(input int which, input logic level);
		case (which)
			B_MODE:  i_btn_mode = level;
			B_POS:   i_btn_pos = level;
			B_INC:   i_btn_inc = level;
			default: i_btn_alarm = level;
		endcase
	endtask

	task automatic press_button(input int which);
		drive_button(which, 1'b1);
		repeat (PRESS_HOLD) @(negedge clk);
		drive_button(which, 1'b0);
		repeat (PRESS_HOLD) @(negedge clk);
	endtask

	task automatic inc_unit(input int u, input int n, input bit on_alarm);
		repeat (n) press_button(B_INC);
		if (on_alarm) begin
			alm_t = bump_unit(alm_t, u, n);
		end else begin
			run_t = bump_unit(run_t, u, n);
		end
	endtask

	// One full scan with the enables checked for order and a single low bit
	task automatic read_scan();
		logic [2:0]         idx;
		logic [2:0]         prev;
		logic [`DIGITS-1:0] seen;
		seen = '0;
		prev = 3'd0;
		repeat (SCAN_CYC) begin
			@(negedge clk);
			assert ($countones(~seg_enb) == 1)
			else fail_check("o_seg_enb does not hold exactly one low bit");
			idx = 3'd0;
			for (int k = 0; k < `DIGITS; k++) begin
				if (!seg_enb[k]) begin
					idx = 3'(k);
				end
			end
			assert (seen == '0 || idx == prev || idx == ((prev == 3'd5) ? 3'd0 : prev + 3'd1))
			else value_error("o_seg_enb digit index", 32'(prev), 32'(idx));
			got[idx] = seg;
			seen[idx] = 1'b1;
			prev = idx;
		end
		assert (&seen) else fail_check("a digit was never enabled during the scan");
	endtask

	// Repeats scans until two in a row agree so that a second tick cannot split one
	task automatic read_stable();
		logic [`DIGITS-1:0][`SEG_W-1:0] last;
		int tries;
		tries = 0;
		read_scan();
		do begin
			last = got;
			read_scan();
			tries++;
		end while (last != got && tries < 4);
		assert (last == got) else fail_check("the display kept changing between scans");
	endtask

	task automatic check_display(input int t);
		exp_t = t;
		cmp_req = ~cmp_req;
		wait (cmp_ack == cmp_req);
	endtask

	// Running time is known only to within a few ticks
	task automatic check_running(input int lo, input int span);
		int pick;
		pick = lo % DAY;
		for (int n = span; n >= 0; n--) begin
			if (scan_matches((lo + n) % DAY)) begin
				pick = (lo + n) % DAY;
			end
		end
		run_t = pick;
		check_display(run_t);
	endtask

	// Compare process
	always begin
		wait (cmp_req != cmp_ack);
		for (int k = 0; k < `DIGITS; k++) begin
			assert (got[k] == ref_seg(exp_t, k))
			else value_error($sformatf("o_seg digit %0d", k), 32'(ref_seg(exp_t, k)), 32'(got[k]));
		end
		cmp_ack = cmp_req;
	end

	// Watchdog
	initial begin
		#(LIMIT_CYC * 2 * HALF_PERIOD);
		$display("Timeout: the tests did not finish within %0d clock cycles", LIMIT_CYC);
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	// ----------------------------------------------------------------------
	// Test sequence
	// ----------------------------------------------------------------------
	initial begin
		int target;
		int gap;
		int low_cyc;
		int waited;
		clk         = 1'b0;
		rst_n       = 1'b0;
		i_btn_mode  = 1'b0;
		i_btn_pos   = 1'b0;
		i_btn_inc   = 1'b0;
		i_btn_alarm = 1'b0;
		run_t       = 0;
		alm_t       = 0;
		exp_t       = 0;
		void'($urandom(32'h319b));
		repeat (10) @(negedge clk);
		rst_n = 1'b1;

		// After reset
		assert (alarm == 1'b0) else value_error("o_alarm", 32'h0, 32'(alarm));
		read_scan();
		check_display(0);

		// Setup entry with random increments on each unit
		press_button(B_MODE);
		inc_unit(U_SEC, int'($urandom % 32'd59) + 1, 1'b0);
		press_button(B_POS);
		inc_unit(U_MIN, int'($urandom % 32'd59) + 1, 1'b0);
		press_button(B_POS);
		inc_unit(U_HOU, int'($urandom % 32'd59) + 1, 1'b0);
		read_stable();
		check_display(run_t);
		read_scan();
		check_display(run_t);
		read_scan();
		check_display(run_t);

		// Hours wrap without touching minutes or seconds
		inc_unit(U_HOU, 25, 1'b0);
		read_stable();
		check_display(run_t);

		// Set 00:59:58 and let it run across the hour
		inc_unit(U_HOU, steps_to(run_t, U_HOU, 0), 1'b0);
		press_button(B_POS);
		inc_unit(U_SEC, steps_to(run_t, U_SEC, 58), 1'b0);
		press_button(B_POS);
		inc_unit(U_MIN, steps_to(run_t, U_MIN, 59), 1'b0);
		press_button(B_POS);
		read_stable();
		check_display(59 * 60 + 58);
		press_button(B_MODE);
		press_button(B_MODE);
		repeat (RUN_SECS * TICK_DIV) @(negedge clk);
		read_stable();
		check_running(run_t + RUN_SECS, 1);

		// Alarm set eight seconds past the frozen time
		press_button(B_MODE);
		read_stable();
		check_running(run_t, 1);
		target = (run_t + 8) % DAY;
		press_button(B_MODE);
		inc_unit(U_HOU, steps_to(alm_t, U_HOU, unit_of(target, U_HOU)), 1'b1);
		press_button(B_POS);
		inc_unit(U_SEC, steps_to(alm_t, U_SEC, unit_of(target, U_SEC)), 1'b1);
		press_button(B_POS);
		inc_unit(U_MIN, steps_to(alm_t, U_MIN, unit_of(target, U_MIN)), 1'b1);
		press_button(B_POS);
		read_stable();
		check_display(alm_t);
		press_button(B_MODE);
		read_stable();
		check_running(run_t, 4);
		gap = (alm_t - run_t + DAY) % DAY;
		assert (gap >= 3) else fail_check("the alarm time is not far enough ahead");

		press_button(B_ALARM);
		low_cyc = (gap - 1) * TICK_DIV - TICK_DIV / 2 - PRESS_CYC;
		repeat (low_cyc) begin
			@(negedge clk);
			assert (alarm == 1'b0) else value_error("o_alarm", 32'h0, 32'(alarm));
		end
		waited = 0;
		while (alarm !== 1'b1 && waited < 3 * TICK_DIV + TICK_DIV / 2) begin
			@(negedge clk);
			waited++;
		end
		assert (alarm == 1'b1) else fail_check("o_alarm did not rise within two ticks of the match");
		press_button(B_ALARM);
		assert (alarm == 1'b0) else value_error("o_alarm", 32'h0, 32'(alarm));

		$display("Test passed");
		$finish;
	end

endmodule

/* tb.f */
+incdir+hdl
hdl/clock_pkg.sv
hdl/button_decode.sv
hdl/hms_counter.sv
hdl/time_keeper.sv
hdl/display_scan.sv
hdl/digital_clock.sv
sim/tb_digital_clock.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compiles the digital clock testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	--top-module tb_digital_clock -f tb.f -o tb_digital_clock \
	&& ./obj_dir/tb_digital_clock > sim.log 2>&1 \
	|| echo "Build or simulation ended with an error status"

[ -f sim.log ] && cat sim.log

grep -qx "Test passed" sim.log 2>/dev/null \
	&& echo "RESULT: PASS" \
	|| { echo "RESULT: FAIL"; exit 1; }
